//--- mem_defs.svh
// Memory subsystem parameters
// Address and word widths, RAM size and read latency
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Byte address from the core
`define MEM_ADDR_W 20

// One memory word, two bytes
`define MEM_DATA_W 16

// RAM depth in words is 2**RAM_WORDS_LOG2, so 4 KiB of bytes
// Addresses above that wrap around
`define RAM_WORDS_LOG2 11

// Cycles from read issue to data on the RAM output
// The controller sequence is built around this being 2
`define MEM_CAS_LAT 2

`endif

//--- mem_pkg.sv
// Shared types of the memory subsystem
// CPU request, RAM command and byte-lane views of memory data
`include "mem_defs.svh"

package mem_pkg;

    // One memory word split into its byte lanes
    typedef struct packed {
        logic [`MEM_DATA_W/2-1:0] hi;   // Byte at odd address
        logic [`MEM_DATA_W/2-1:0] lo;   // Byte at even address
    } mem_word_t;

    // Data request as presented by the core
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;   // Any byte address
        mem_word_t              wdata;  // Little-endian write data
        logic                   write;
    } cpu_req_t;

    // Command to the RAM, valid every cycle
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;   // Bit 0 ignored by RAM
        mem_word_t              wdata;
        logic                   we;
    } mem_cmd_t;

    // Six instruction bytes starting at IP
    typedef struct packed {
        logic [7:0] b5;
        logic [7:0] b4;
        logic [7:0] b3;
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;                 // Byte at IP
    } instr_window_t;

endpackage

//--- mem_cntrl.sv
// Memory controller for on-chip RAM with CAS latency 2
// Fills a 6-byte instruction window and serves byte-addressed 16-bit data access
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_cntrl (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  mem_pkg::cpu_req_t             i_req,
    input  logic [`MEM_ADDR_W-1:0]        i_ip,
    output mem_pkg::mem_word_t            o_rdata,
    output mem_pkg::instr_window_t        o_window,
    output logic                          o_ready,
    output mem_pkg::mem_cmd_t             o_mem_cmd,
    input  mem_pkg::mem_word_t            i_mem_rdata
);

    localparam int AW      = `MEM_ADDR_W;
    localparam int BYTE_AW = `RAM_WORDS_LOG2 + 1;   // Byte address bits inside the RAM
    localparam int CAS_LAT = `MEM_CAS_LAT;

    typedef enum logic [3:0] {
        S_IDLE,
        S_F1, S_F2, S_F3, S_F4, S_F5, S_F6,         // Instruction line fill
        S_D1, S_D2, S_D3, S_D4, S_D5                // Data access
    } state_t;

    state_t                 state_q;
    logic                   ip_vld;
    logic                   ad_vld;
    logic                   ready_q;
    logic [AW-1:0]          l_ip;           // IP held in the line
    logic [AW-1:0]          l_addr;         // Last data address served
    logic [55:0]            line_q;         // Four words, top byte only for odd IP
    mem_pkg::mem_word_t     rdata_q;
    logic [AW-1:0]          cmd_addr_q;
    mem_pkg::mem_word_t     cmd_wdata_q;
    logic                   cmd_we_q;

    logic                   ip_chg;
    logic                   ad_chg;
    logic                   fill_go;
    logic                   fill_last;
    logic                   data_go;
    logic [BYTE_AW-1:0]     win_off;
    logic                   win_hit;
    logic                   unaligned_wr;

    // A clear valid flag forces the first access after reset
    assign ip_chg = !ip_vld || (i_ip != l_ip);
    assign ad_chg = !ad_vld || (i_req.addr != l_addr);

    assign fill_go   = (state_q == S_IDLE) && ip_chg;
    assign fill_last = ((state_q == S_F5) && !l_ip[0]) || (state_q == S_F6);

    // Data goes after the fill without a stop in idle
    assign data_go = ad_chg && (((state_q == S_IDLE) && !ip_chg) || fill_last);

    // Written bytes addr and addr+1 against window l_ip..l_ip+5, modulo RAM size
    assign win_off = l_addr[BYTE_AW-1:0] - l_ip[BYTE_AW-1:0] + BYTE_AW'(1);
    assign win_hit = (win_off <= BYTE_AW'(6));

    assign unaligned_wr = i_req.write && l_addr[0];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q  <= S_IDLE;
            ip_vld   <= 1'b0;
            ad_vld   <= 1'b0;
            ready_q  <= 1'b0;
            cmd_we_q <= 1'b0;
        end else begin
            ready_q <= (state_q == S_IDLE) && !ip_chg && !ad_chg;

            case (state_q)
                S_IDLE: begin
                    if (ip_chg) begin
                        state_q <= S_F1;
                        ip_vld  <= 1'b1;
                    end
                end
                S_F1: state_q <= S_F2;
                S_F2: state_q <= S_F3;
                S_F3: state_q <= S_F4;
                S_F4: state_q <= S_F5;
                S_F5: state_q <= l_ip[0] ? S_F6 : S_IDLE;
                S_F6: state_q <= S_IDLE;
                S_D1: state_q <= S_D2;
                S_D2: state_q <= S_D3;
                S_D3: begin
                    cmd_we_q <= i_req.write;            // First word write
                    // Refill if the write lands in the window
                    if (i_req.write && win_hit) begin
                        ip_vld <= 1'b0;
                    end
                    state_q <= (i_req.write || l_addr[0]) ? S_D4 : S_IDLE;
                end
                S_D4: begin
                    cmd_we_q <= unaligned_wr;           // Second word only when split
                    state_q  <= unaligned_wr ? S_D5 : S_IDLE;
                end
                S_D5: begin
                    cmd_we_q <= 1'b0;
                    state_q  <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase

            if (data_go) begin
                state_q <= S_D1;
                ad_vld  <= 1'b1;
            end
        end
    end

    // Datapath, follows the FSM above
    always_ff @(posedge clk) begin
        case (state_q)
            S_F1, S_F2: cmd_addr_q <= cmd_addr_q + AW'(2);
            S_F3: begin
                cmd_addr_q    <= cmd_addr_q + AW'(2);
                line_q[15:0]  <= i_mem_rdata;       // Word at IP arrives
            end
            S_F4: line_q[31:16] <= i_mem_rdata;
            S_F5: line_q[47:32] <= i_mem_rdata;
            S_F6: line_q[55:48] <= i_mem_rdata.lo;  // Only the low byte is in the window
            S_D1: cmd_addr_q <= cmd_addr_q + AW'(2);    // Neighbor word next
            S_D3: begin
                if (i_req.write) begin
                    cmd_addr_q <= {l_addr[AW-1:1], 1'b0};
                    rdata_q    <= i_req.wdata;
                    if (l_addr[0]) begin
                        cmd_wdata_q.hi <= i_req.wdata.lo;
                        cmd_wdata_q.lo <= i_mem_rdata.lo;   // Keep byte below
                    end else begin
                        cmd_wdata_q <= i_req.wdata;
                    end
                end else if (l_addr[0]) begin
                    rdata_q.lo <= i_mem_rdata.hi;
                end else begin
                    rdata_q <= i_mem_rdata;
                end
            end
            S_D4: begin
                if (unaligned_wr) begin
                    cmd_addr_q     <= cmd_addr_q + AW'(2);
                    cmd_wdata_q.hi <= i_mem_rdata.hi;       // Keep byte above
                    cmd_wdata_q.lo <= i_req.wdata.hi;
                end else if (!i_req.write) begin
                    rdata_q.hi <= i_mem_rdata.lo;
                end
            end
            default: ;
        endcase

        if (fill_go) begin
            l_ip       <= i_ip;
            cmd_addr_q <= {i_ip[AW-1:1], 1'b0};
        end
        if (data_go) begin
            l_addr     <= i_req.addr;
            cmd_addr_q <= {i_req.addr[AW-1:1], 1'b0};
        end
    end

    // Drops at once when the core moves on
    assign o_ready   = ready_q && !ip_chg && !ad_chg;
    assign o_rdata   = rdata_q;
    assign o_window  = mem_pkg::instr_window_t'(l_ip[0] ? line_q[55:8] : line_q[47:0]);
    assign o_mem_cmd = '{addr: cmd_addr_q, wdata: cmd_wdata_q, we: cmd_we_q};

    // RAM timing is hard-wired into the F and D state sequences
    cas_lat_a: assert property (@(posedge clk) CAS_LAT == 2)
        else $error("mem_cntrl needs CAS latency 2, got %0d", CAS_LAT);

    ready_no_we_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ready |-> !cmd_we_q)
        else $error("write enable high while ready");

    // A new request must never see stale ready
    ready_low_a: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_ip != $past(i_ip) || i_req.addr != $past(i_req.addr)) |-> !o_ready ##1 !o_ready)
        else $error("ready not low after request change");

endmodule

//--- onchip_ram.sv
// Synchronous on-chip RAM, one 16-bit word per even address
// Registered read pipeline of CAS latency depth, write in the issue cycle
`timescale 1ns/1ps
`include "mem_defs.svh"

module onchip_ram (
    input  logic                clk,
    input  mem_pkg::mem_cmd_t   i_cmd,
    output mem_pkg::mem_word_t  o_rdata
);

    localparam int WL      = `RAM_WORDS_LOG2;
    localparam int DEPTH   = 1 << WL;
    localparam int CAS_LAT = `MEM_CAS_LAT;

    mem_pkg::mem_word_t ram [DEPTH];
    mem_pkg::mem_word_t rd_pipe [CAS_LAT];   // Several reads in flight during a fill
    logic [WL-1:0]      idx;

    // Bit 0 selects a byte, the controller handles that
    assign idx = i_cmd.addr[WL:1];

    always_ff @(posedge clk) begin
        if (i_cmd.we) begin
            ram[idx] <= i_cmd.wdata;
        end
        rd_pipe[0] <= ram[idx];
        for (int i = 1; i < CAS_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign o_rdata = rd_pipe[CAS_LAT-1];

    // An X here would silently corrupt the array
    we_known_a: assert property (@(posedge clk) !$isunknown(i_cmd.we))
        else $error("RAM write enable unknown");

endmodule

//--- mem_subsys_top.sv
// Memory subsystem top
// Controller in front of the on-chip RAM, CPU side exposed
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_top (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  mem_pkg::cpu_req_t             i_req,
    input  logic [`MEM_ADDR_W-1:0]        i_ip,
    output mem_pkg::mem_word_t            o_rdata,
    output mem_pkg::instr_window_t        o_window,
    output logic                          o_ready
);

    mem_pkg::mem_cmd_t  mem_cmd;      // Controller to RAM
    mem_pkg::mem_word_t ram_rdata;    // Two cycles behind the read command

    mem_cntrl u_cntrl (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_ip        (i_ip),
        .o_rdata     (o_rdata),
        .o_window    (o_window),
        .o_ready     (o_ready),
        .o_mem_cmd   (mem_cmd),
        .i_mem_rdata (ram_rdata)
    );

    onchip_ram u_ram (
        .clk     (clk),
        .i_cmd   (mem_cmd),
        .o_rdata (ram_rdata)
    );

endmodule

//--- tb_clkgen.sv
// Testbench clock source
// Free-running clock, low at time zero
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

//--- tb_mem_subsys.sv
// Testbench for the memory subsystem
// Table-driven CPU requests checked against a byte-array model of the RAM
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsys;

    localparam int N_STEPS       = 36;
    localparam int PRELOAD_WORDS = 64;                  // Bytes 0x00..0x7F used by the table
    localparam int BYTE_AW       = `RAM_WORDS_LOG2 + 1;
    localparam int RAM_BYTES     = 1 << BYTE_AW;
    localparam int WDOG_CYCLES   = (N_STEPS + PRELOAD_WORDS) * 20 + 50;
    localparam logic RD          = 1'b0;
    localparam logic WR          = 1'b1;

    typedef struct packed {
        logic                   wr;
        logic [`MEM_ADDR_W-1:0] addr;
        mem_pkg::mem_word_t     wdata;
        logic [`MEM_ADDR_W-1:0] ip;
        logic                   rnd;    // Write data from the LCG
    } step_t;

    logic                       clk;
    logic                       rst_n;
    mem_pkg::cpu_req_t          cpu_req;
    logic [`MEM_ADDR_W-1:0]     cpu_ip;
    mem_pkg::mem_word_t         rdata;
    mem_pkg::instr_window_t     window;
    logic                       ready;

    step_t                      steps [N_STEPS];
    logic [7:0]                 model [RAM_BYTES];
    int unsigned                lcg_state;
    int                         err_cnt;
    int                         chk_cnt;
    int                         cur_step;
    string                      phase;

    tb_clkgen #(.PERIOD_NS(100)) u_clkgen (.o_clk(clk));

    mem_subsys_top uut (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .i_req    (cpu_req),
        .i_ip     (cpu_ip),
        .o_rdata  (rdata),
        .o_window (window),
        .o_ready  (ready)
    );

    function automatic step_t make_step(logic wr, logic [`MEM_ADDR_W-1:0] addr,
                                        logic [15:0] wdata, logic [`MEM_ADDR_W-1:0] ip,
                                        logic rnd);
        step_t s;
        s.wr    = wr;
        s.addr  = addr;
        s.wdata = wdata;
        s.ip    = ip;
        s.rnd   = rnd;
        return s;
    endfunction

    task automatic load_steps();
        steps[0]  = make_step(RD, 20'h00000, 16'h0000, 20'h00000, 1'b0);  // First request
        steps[1]  = make_step(WR, 20'h00040, 16'hA55A, 20'h00000, 1'b0);
        steps[2]  = make_step(RD, 20'h00042, 16'h0000, 20'h00000, 1'b0);  // Neighbor above
        steps[3]  = make_step(RD, 20'h00040, 16'h0000, 20'h00000, 1'b0);
        steps[4]  = make_step(RD, 20'h0003E, 16'h0000, 20'h00000, 1'b0);  // Neighbor below
        steps[5]  = make_step(WR, 20'h00050, 16'h1122, 20'h00000, 1'b0);
        steps[6]  = make_step(WR, 20'h00052, 16'h3344, 20'h00000, 1'b0);
        steps[7]  = make_step(WR, 20'h00051, 16'hBEEF, 20'h00000, 1'b0);  // Split write
        steps[8]  = make_step(RD, 20'h00050, 16'h0000, 20'h00000, 1'b0);
        steps[9]  = make_step(RD, 20'h00052, 16'h0000, 20'h00000, 1'b0);
        steps[10] = make_step(RD, 20'h00051, 16'h0000, 20'h00000, 1'b0);
        steps[11] = make_step(WR, 20'h00020, 16'h0201, 20'h00000, 1'b0);
        steps[12] = make_step(WR, 20'h00022, 16'h0403, 20'h00000, 1'b0);
        steps[13] = make_step(WR, 20'h00024, 16'h0605, 20'h00000, 1'b0);
        steps[14] = make_step(WR, 20'h00026, 16'h0807, 20'h00000, 1'b0);
        steps[15] = make_step(RD, 20'h00022, 16'h0000, 20'h00020, 1'b0);  // Even IP
        steps[16] = make_step(RD, 20'h00022, 16'h0000, 20'h00021, 1'b0);  // Odd IP only
        steps[17] = make_step(RD, 20'h00024, 16'h0000, 20'h00023, 1'b0);
        steps[18] = make_step(WR, 20'h00025, 16'hCAFE, 20'h00023, 1'b0);  // Inside window
        steps[19] = make_step(WR, 20'h00022, 16'hD00D, 20'h00023, 1'b0);  // Covers byte 0
        steps[20] = make_step(WR, 20'h00028, 16'h7788, 20'h00023, 1'b0);  // Covers byte 5
        steps[21] = make_step(WR, 20'h00061, 16'h1357, 20'h00060, 1'b0);
        steps[22] = make_step(WR, 20'h00010, 16'h0000, 20'h00060, 1'b1);
        steps[23] = make_step(RD, 20'h00011, 16'h0000, 20'h0000F, 1'b0);
        steps[24] = make_step(WR, 20'h0000F, 16'h0000, 20'h0000F, 1'b1);
        steps[25] = make_step(RD, 20'h0000E, 16'h0000, 20'h00012, 1'b0);
        steps[26] = make_step(WR, 20'h00033, 16'h0000, 20'h00030, 1'b1);
        steps[27] = make_step(RD, 20'h00032, 16'h0000, 20'h00031, 1'b0);
        steps[28] = make_step(WR, 20'h0006C, 16'h0000, 20'h00031, 1'b1);
        steps[29] = make_step(RD, 20'h0006D, 16'h0000, 20'h00068, 1'b0);
        steps[30] = make_step(WR, 20'h0006E, 16'h0000, 20'h0006B, 1'b1);
        steps[31] = make_step(RD, 20'h0006C, 16'h0000, 20'h0006B, 1'b0);
        steps[32] = make_step(RD, 20'h40040, 16'h0000, 20'h0006B, 1'b0);  // Wraps to 0x040
        steps[33] = make_step(WR, 20'hF0045, 16'h0000, 20'h10044, 1'b1);
        steps[34] = make_step(RD, 20'h00044, 16'h0000, 20'h00044, 1'b0);
        steps[35] = make_step(RD, 20'h00000, 16'h0000, 20'h00001, 1'b0);
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Byte offset k from a, wrapped to the RAM size
    function automatic logic [BYTE_AW-1:0] byte_idx(logic [`MEM_ADDR_W-1:0] a, int k);
        logic [`MEM_ADDR_W-1:0] s;
        s = a + `MEM_ADDR_W'(k);
        return s[BYTE_AW-1:0];
    endfunction

    function automatic mem_pkg::mem_word_t model_word(logic [`MEM_ADDR_W-1:0] a);
        mem_pkg::mem_word_t w;
        w.lo = model[byte_idx(a, 0)];
        w.hi = model[byte_idx(a, 1)];
        return w;
    endfunction

    function automatic mem_pkg::instr_window_t model_window(logic [`MEM_ADDR_W-1:0] ip);
        mem_pkg::instr_window_t w;
        w.b0 = model[byte_idx(ip, 0)];
        w.b1 = model[byte_idx(ip, 1)];
        w.b2 = model[byte_idx(ip, 2)];
        w.b3 = model[byte_idx(ip, 3)];
        w.b4 = model[byte_idx(ip, 4)];
        w.b5 = model[byte_idx(ip, 5)];
        return w;
    endfunction

    task automatic model_write(input logic [`MEM_ADDR_W-1:0] a, input mem_pkg::mem_word_t d);
        model[byte_idx(a, 0)] = d.lo;
        model[byte_idx(a, 1)] = d.hi;
    endtask

    task automatic check_word(input string name, input mem_pkg::mem_word_t got,
                              input mem_pkg::mem_word_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_window(input string name, input mem_pkg::instr_window_t got,
                                input mem_pkg::instr_window_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAILED %0t %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("FAILED %0t %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic drive(input mem_pkg::cpu_req_t req, input logic [`MEM_ADDR_W-1:0] ip);
        @(posedge clk);
        cpu_req <= req;
        cpu_ip  <= ip;
    endtask

    // Outputs sampled on the falling edge, away from register updates
    task automatic wait_ready();
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
    endtask

    task automatic run_step(input int idx, input step_t s);
        mem_pkg::cpu_req_t req;
        int                errs_before;
        req.addr  = s.addr;
        req.write = s.wr;
        if (s.rnd) begin
            req.wdata = lcg_next();
        end else begin
            req.wdata = s.wdata;
        end
        errs_before = err_cnt;
        cur_step    = idx;
        drive(req, s.ip);
        wait_ready();
        if (req.write) begin
            model_write(req.addr, req.wdata);
        end
        check_word("o_rdata", rdata, model_word(req.addr));
        check_window("o_window", window, model_window(s.ip));
        $display("step %2d %s addr=%05h ip=%05h data=%04h : %s", idx, s.wr ? "W" : "R",
                 req.addr, s.ip, req.wdata, (err_cnt == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin : main
        mem_pkg::cpu_req_t req;
        rst_n     = 1'b0;
        cpu_req   = '0;
        cpu_ip    = '0;
        lcg_state = 32'd15729;
        err_cnt   = 0;
        chk_cnt   = 0;
        cur_step  = 0;
        phase     = "preload";
        for (int i = 0; i < RAM_BYTES; i++) begin
            model[i] = 8'h00;
        end
        load_steps();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("o_ready after reset", ready, 1'b0);

        // Zero the RAM region the table touches, IP held at 0
        for (int k = 0; k < PRELOAD_WORDS; k++) begin
            cur_step  = k;
            req.addr  = `MEM_ADDR_W'(2 * k);
            req.wdata = '0;
            req.write = 1'b1;
            drive(req, '0);
            wait_ready();
            check_word("o_rdata", rdata, model_word(req.addr));
        end
        $display("preload: %0d words zeroed, %0d errors", PRELOAD_WORDS, err_cnt);

        phase = "table";
        for (int i = 0; i < N_STEPS; i++) begin
            run_step(i, steps[i]);
        end

        $display("%0d steps, %0d checks, %0d errors", PRELOAD_WORDS + N_STEPS, chk_cnt,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout: o_ready never came in %s step %0d within %0d cycles", phase,
                 cur_step, WDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
mem_pkg.sv
mem_cntrl.sv
onchip_ram.sv
mem_subsys_top.sv
tb_clkgen.sv
tb_mem_subsys.sv

//--- Makefile
TOP = tb_mem_subsys

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
